/* hist_peak_top.f */
logic/hist_pkg.sv
logic/hist_wr_if.sv
logic/hist_rd_if.sv
logic/hit_sequencer.sv
logic/hist_bank_ram.sv
logic/peak_finder.sv
logic/hist_peak_top.sv
+incdir+tb
tb/hist_peak_tb.sv

/* logic/hist_bank_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module hist_bank_ram (
    input  logic      clk,
    input  logic      combin_res,
    hist_wr_if.buffer wr_port,
    hist_rd_if.buffer rd_port
);

    // two banks of counts, entry index is {pixel, bin}
    logic [hist_pkg::COUNT_W-1:0] mem [2][hist_pkg::ENTRY_NUM];

    // bank currently collecting hits, the other one belongs to the scan
    logic                        fill_sel;
    logic                        scan_sel;

    logic [hist_pkg::ADDR_W-1:0] wr_addr;
    logic [hist_pkg::ADDR_W-1:0] rd_addr;

    // frame closes with this increment
    logic                        swap;

    assign scan_sel = ~fill_sel;
    assign wr_addr  = {wr_port.pixel, wr_port.bin};
    assign rd_addr  = {rd_port.rd_pixel, rd_port.rd_bin};
    assign swap     = wr_port.wr && wr_port.frame_last;

    // read port always looks at the finished bank
    assign rd_port.rd_count = mem[scan_sel][rd_addr];

    // count storage
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            // both banks start empty, a partial frame is dropped
            for (int b = 0; b < 2; b++) begin
                for (int e = 0; e < hist_pkg::ENTRY_NUM; e++) begin
                    mem[b][e] <= '0;
                end
            end
        end else begin
            // increment in the fill bank, still the old one on a swap edge
            if (wr_port.wr) begin
                mem[fill_sel][wr_addr] <= mem[fill_sel][wr_addr] + 1'b1;
            end
            // clear on read, so a released bank is empty again
            // no collision with the write, the banks differ
            if (rd_port.rd) begin
                mem[scan_sel][rd_addr] <= '0;
            end
        end
    end

    // bank select and hand-off level
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            fill_sel           <= 1'b0;
            rd_port.bank_ready <= 1'b0;
        end else begin
            if (swap) begin
                fill_sel <= ~fill_sel;
            end
            // set at the swap, dropped by the release pulse
            if (swap) begin
                rd_port.bank_ready <= 1'b1;
            end else if (rd_port.bank_release) begin
                rd_port.bank_ready <= 1'b0;
            end
        end
    end

    // scan only reads a bank that was handed over
    a_rd_while_ready: assert property (
        @(posedge clk) disable iff (!combin_res)
        rd_port.rd |-> rd_port.bank_ready
    );

    // previous bank must be released before the next frame closes
    a_no_swap_busy: assert property (
        @(posedge clk) disable iff (!combin_res)
        swap |-> !rd_port.bank_ready
    );

    // counter headroom, a full count must never be incremented
    a_no_count_wrap: assert property (
        @(posedge clk) disable iff (!combin_res)
        wr_port.wr |-> (mem[fill_sel][wr_addr] != '1)
    );

endmodule

`default_nettype wire

/* logic/hist_peak_top.sv */
`timescale 1ns/1ns
`default_nettype none

module hist_peak_top (
    input  logic                         clk,
    input  logic                         combin_res,
    // photon strobe and its time code
    input  logic                         hit,
    input  logic [hist_pkg::TIME_W-1:0]  hit_time,
    // per-pixel peak report
    output logic                         peak_valid,
    output logic [hist_pkg::PIXEL_W-1:0] peak_pixel,
    output logic [hist_pkg::BIN_W-1:0]   peak_bin,
    output logic [hist_pkg::COUNT_W-1:0] peak_count,
    output logic                         frame_done
);

    // increment requests, sequencer to memory
    hist_wr_if wr_bus ();
    // bank hand-off and bin reads, memory to peak search
    hist_rd_if rd_bus ();

    // hit order tracking and binning
    hit_sequencer hit_sequencer_inst (
        .clk        (clk),
        .combin_res (combin_res),
        .hit        (hit),
        .hit_time   (hit_time),
        .wr_port    (wr_bus.producer)
    );

    // ping-pong histogram storage
    hist_bank_ram hist_bank_ram_inst (
        .clk        (clk),
        .combin_res (combin_res),
        .wr_port    (wr_bus.buffer),
        .rd_port    (rd_bus.buffer)
    );

    // scan of the finished bank
    peak_finder peak_finder_inst (
        .clk        (clk),
        .combin_res (combin_res),
        .rd_port    (rd_bus.consumer),
        .peak_valid (peak_valid),
        .peak_pixel (peak_pixel),
        .peak_bin   (peak_bin),
        .peak_count (peak_count),
        .frame_done (frame_done)
    );

endmodule

`default_nettype wire

/* logic/hist_pkg.sv */
`default_nettype none

package hist_pkg;

    // time code width from the tdc front end
    localparam int TIME_W = 8;

    // coarse bin taken from the top bits of the time code
    localparam int BIN_W   = 4;
    localparam int BIN_NUM = 2 ** BIN_W;

    // pixels handled per frame
    localparam int PIXEL_NUM = 4;
    localparam int PIXEL_W   = 2;

    // hits per pixel inside one acquisition, innermost loop
    localparam int HITS_PER_PIXEL = 2;
    localparam int HIT_W          = 1;

    // acquisitions per frame, outer loop
    localparam int ACQ_NUM = 16;
    localparam int ACQ_W   = 4;

    // bin counter width, must hold HITS_PER_PIXEL * ACQ_NUM
    localparam int COUNT_W = 6;

    // hits in one complete frame
    localparam int FRAME_HITS = HITS_PER_PIXEL * PIXEL_NUM * ACQ_NUM;

    // one bank holds every bin of every pixel
    localparam int ENTRY_NUM = PIXEL_NUM * BIN_NUM;
    // entry address is {pixel, bin}
    localparam int ADDR_W    = PIXEL_W + BIN_W;

    // terminal values of the loop counters
    localparam logic [HIT_W-1:0]   HIT_LAST   = HIT_W'(HITS_PER_PIXEL - 1);
    localparam logic [PIXEL_W-1:0] PIXEL_LAST = PIXEL_W'(PIXEL_NUM - 1);
    localparam logic [ACQ_W-1:0]   ACQ_LAST   = ACQ_W'(ACQ_NUM - 1);
    localparam logic [BIN_W-1:0]   BIN_LAST   = BIN_W'(BIN_NUM - 1);

endpackage

`default_nettype wire

/* logic/hist_rd_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface hist_rd_if;

    // finished bank waiting for the scan
    logic                         bank_ready;
    // read strobe and entry address from the scanner
    logic                         rd;
    logic [hist_pkg::PIXEL_W-1:0] rd_pixel;
    logic [hist_pkg::BIN_W-1:0]   rd_bin;
    // combinational count of the addressed entry
    logic [hist_pkg::COUNT_W-1:0] rd_count;
    // pulse after the last read, frees the bank
    logic                         bank_release;

    // histogram memory side
    modport buffer (
        output bank_ready,
        output rd_count,
        input  rd,
        input  rd_pixel,
        input  rd_bin,
        input  bank_release
    );

    // peak search side
    modport consumer (
        input  bank_ready,
        input  rd_count,
        output rd,
        output rd_pixel,
        output rd_bin,
        output bank_release
    );

endinterface

`default_nettype wire

/* logic/hist_wr_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface hist_wr_if;

    // one increment per cycle with wr high
    logic                         wr;
    // target entry of the increment
    logic [hist_pkg::PIXEL_W-1:0] pixel;
    logic [hist_pkg::BIN_W-1:0]   bin;
    // last increment of the frame, bank swaps on the same edge
    logic                         frame_last;

    // sequencer side
    modport producer (
        output wr,
        output pixel,
        output bin,
        output frame_last
    );

    // histogram memory side
    modport buffer (
        input wr,
        input pixel,
        input bin,
        input frame_last
    );

endinterface

`default_nettype wire

/* logic/hit_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module hit_sequencer (
    input  logic                        clk,
    input  logic                        combin_res,
    input  logic                        hit,
    input  logic [hist_pkg::TIME_W-1:0] hit_time,
    hist_wr_if.producer                 wr_port
);

    // nested position of the current hit within the frame
    logic [hist_pkg::HIT_W-1:0]   hit_cnt;
    logic [hist_pkg::PIXEL_W-1:0] pixel_cnt;
    logic [hist_pkg::ACQ_W-1:0]   acq_cnt;

    // wrap conditions, each one implies the inner ones
    logic hit_wrap;
    logic pixel_wrap;
    logic acq_wrap;

    assign hit_wrap   = (hit_cnt == hist_pkg::HIT_LAST);
    assign pixel_wrap = hit_wrap && (pixel_cnt == hist_pkg::PIXEL_LAST);
    // last hit of last pixel of last acquisition
    assign acq_wrap   = pixel_wrap && (acq_cnt == hist_pkg::ACQ_LAST);

    // loop counters only move on a hit strobe
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            hit_cnt   <= '0;
            pixel_cnt <= '0;
            acq_cnt   <= '0;
        end else if (hit) begin
            if (hit_wrap) begin
                hit_cnt <= '0;
            end else begin
                hit_cnt <= hit_cnt + 1'b1;
            end
            // pixel advances after its last hit
            if (hit_wrap) begin
                if (pixel_cnt == hist_pkg::PIXEL_LAST) begin
                    pixel_cnt <= '0;
                end else begin
                    pixel_cnt <= pixel_cnt + 1'b1;
                end
            end
            // acquisition advances after the last pixel
            if (pixel_wrap) begin
                if (acq_wrap) begin
                    acq_cnt <= '0;
                end else begin
                    acq_cnt <= acq_cnt + 1'b1;
                end
            end
        end
    end

    // request strobes, one cycle behind the hit
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            wr_port.wr         <= 1'b0;
            wr_port.frame_last <= 1'b0;
        end else begin
            wr_port.wr         <= hit;
            wr_port.frame_last <= hit && acq_wrap;
        end
    end

    // request address, hit_time ignored without a strobe
    always_ff @(posedge clk) begin
        if (hit) begin
            wr_port.pixel <= pixel_cnt;
            wr_port.bin   <= hit_time[hist_pkg::TIME_W-1 -: hist_pkg::BIN_W];
        end
    end

    // frame close request rides on an increment of the last pixel
    a_last_on_last_pixel: assert property (
        @(posedge clk) disable iff (!combin_res)
        wr_port.frame_last |-> wr_port.wr && (wr_port.pixel == hist_pkg::PIXEL_LAST)
    );

endmodule

`default_nettype wire

/* logic/peak_finder.sv */
`timescale 1ns/1ns
`default_nettype none

module peak_finder (
    input  logic                         clk,
    input  logic                         combin_res,
    hist_rd_if.consumer                  rd_port,
    output logic                         peak_valid,
    output logic [hist_pkg::PIXEL_W-1:0] peak_pixel,
    output logic [hist_pkg::BIN_W-1:0]   peak_bin,
    output logic [hist_pkg::COUNT_W-1:0] peak_count,
    output logic                         frame_done
);

    // scan position, bins inner, pixels outer
    logic [hist_pkg::PIXEL_W-1:0] scan_pixel;
    logic [hist_pkg::BIN_W-1:0]   scan_bin;
    // all entries read, waiting for the bank to drop
    logic                         scan_done;
    logic                         bin_last;
    logic                         last_read;
    // last bin of a pixel was read on the previous edge
    logic                         pixel_end;

    // running maximum and the bin it came from
    logic [hist_pkg::COUNT_W-1:0] run_max;
    logic [hist_pkg::BIN_W-1:0]   run_bin;
    // pixel whose scan just ended
    logic [hist_pkg::PIXEL_W-1:0] end_pixel;

    // one read per cycle while a bank is pending
    assign rd_port.rd       = rd_port.bank_ready && !scan_done;
    assign rd_port.rd_pixel = scan_pixel;
    assign rd_port.rd_bin   = scan_bin;
    // release together with the frame-done pulse
    assign rd_port.bank_release = frame_done;

    assign bin_last  = (scan_bin == hist_pkg::BIN_LAST);
    assign last_read = rd_port.rd && bin_last && (scan_pixel == hist_pkg::PIXEL_LAST);

    // scan counter and report strobes
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            scan_pixel <= '0;
            scan_bin   <= '0;
            scan_done  <= 1'b0;
            pixel_end  <= 1'b0;
            peak_valid <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            if (rd_port.rd) begin
                if (bin_last) begin
                    scan_bin <= '0;
                end else begin
                    scan_bin <= scan_bin + 1'b1;
                end
                if (bin_last) begin
                    if (scan_pixel == hist_pkg::PIXEL_LAST) begin
                        scan_pixel <= '0;
                    end else begin
                        scan_pixel <= scan_pixel + 1'b1;
                    end
                end
            end
            // hold off reads until bank_ready falls
            if (last_read) begin
                scan_done <= 1'b1;
            end else if (frame_done) begin
                scan_done <= 1'b0;
            end
            pixel_end  <= rd_port.rd && bin_last;
            peak_valid <= pixel_end;
            // one cycle after the last pixel's report
            frame_done <= peak_valid && (peak_pixel == hist_pkg::PIXEL_LAST);
        end
    end

    // max tracking and result registers
    always_ff @(posedge clk) begin
        if (rd_port.rd) begin
            // bin 0 restarts the search, strictly greater keeps the lowest bin on ties
            if ((scan_bin == '0) || (rd_port.rd_count > run_max)) begin
                run_max <= rd_port.rd_count;
                run_bin <= scan_bin;
            end
            if (bin_last) begin
                end_pixel <= scan_pixel;
            end
        end
        // run_* already include the last bin here
        if (pixel_end) begin
            peak_pixel <= end_pixel;
            peak_bin   <= run_bin;
            peak_count <= run_max;
        end
    end

    // reports are strobes, never levels
    a_peak_pulse: assert property (
        @(posedge clk) disable iff (!combin_res)
        peak_valid |=> !peak_valid
    );

    a_done_pulse: assert property (
        @(posedge clk) disable iff (!combin_res)
        frame_done |=> !frame_done
    );

endmodule

`default_nettype wire

/* tb/hist_peak_model.svh */
`ifndef HIST_PEAK_MODEL_SVH
`define HIST_PEAK_MODEL_SVH
`default_nettype none

// histogram of the frame currently being driven
int model_hist [hist_pkg::PIXEL_NUM][hist_pkg::BIN_NUM];

// expected peak reports, one entry per pixel of each finished frame
logic [hist_pkg::PIXEL_W-1:0] exp_pixel_q [$];
logic [hist_pkg::BIN_W-1:0]   exp_bin_q [$];
logic [hist_pkg::COUNT_W-1:0] exp_count_q [$];

// front entry, compared against each peak report
logic                         head_valid = 1'b0;
logic [hist_pkg::PIXEL_W-1:0] head_pixel = '0;
logic [hist_pkg::BIN_W-1:0]   head_bin   = '0;
logic [hist_pkg::COUNT_W-1:0] head_count = '0;

// copy the queue fronts into the head registers
task automatic refresh_head();
    head_valid = (exp_pixel_q.size() > 0);
    if (head_valid) begin
        head_pixel = exp_pixel_q[0];
        head_bin   = exp_bin_q[0];
        head_count = exp_count_q[0];
    end
endtask

// empty histogram, also drops a partial frame
task automatic model_clear();
    for (int p = 0; p < hist_pkg::PIXEL_NUM; p++) begin
        for (int b = 0; b < hist_pkg::BIN_NUM; b++) begin
            model_hist[p][b] = 0;
        end
    end
endtask

// coarse bin is the top of the time code
task automatic model_add(input int pixel, input logic [hist_pkg::TIME_W-1:0] t);
    model_hist[pixel][t[hist_pkg::TIME_W-1 -: hist_pkg::BIN_W]]++;
endtask

// peak per pixel, strictly greater so the lowest bin keeps a tie
task automatic model_close_frame();
    int best_bin;
    int best_cnt;
    for (int p = 0; p < hist_pkg::PIXEL_NUM; p++) begin
        best_bin = 0;
        best_cnt = model_hist[p][0];
        for (int b = 1; b < hist_pkg::BIN_NUM; b++) begin
            if (model_hist[p][b] > best_cnt) begin
                best_bin = b;
                best_cnt = model_hist[p][b];
            end
        end
        exp_pixel_q.push_back(hist_pkg::PIXEL_W'(p));
        exp_bin_q.push_back(hist_pkg::BIN_W'(best_bin));
        exp_count_q.push_back(hist_pkg::COUNT_W'(best_cnt));
    end
    model_clear();
    refresh_head();
endtask

// report consumed
task automatic model_pop();
    void'(exp_pixel_q.pop_front());
    void'(exp_bin_q.pop_front());
    void'(exp_count_q.pop_front());
    refresh_head();
endtask

`default_nettype wire
`endif

/* tb/hist_peak_tb.sv */
`timescale 1ns/1ns
`include "hist_peak_model.svh"
`default_nettype none

module hist_peak_tb;

    localparam int CLK_PERIOD = 20;
    localparam logic [31:0] SEED = 32'h256abe5f;
    localparam int LOW_W = hist_pkg::TIME_W - hist_pkg::BIN_W;
    // six full frames plus one cut short by reset
    localparam int RUN_FRAMES   = 7;
    localparam int PARTIAL_HITS = 77;
    localparam int WATCHDOG_NS  = RUN_FRAMES * hist_pkg::FRAME_HITS * 4 * CLK_PERIOD;
    // time code patterns
    localparam int MODE_RANDOM = 0;
    localparam int MODE_SINGLE = 1;
    localparam int MODE_TIE    = 2;

    logic                         clk = 1'b0;
    logic                         combin_res;
    logic                         hit;
    logic [hist_pkg::TIME_W-1:0]  hit_time;
    logic                         peak_valid;
    logic [hist_pkg::PIXEL_W-1:0] peak_pixel;
    logic [hist_pkg::BIN_W-1:0]   peak_bin;
    logic [hist_pkg::COUNT_W-1:0] peak_count;
    logic                         frame_done;

    // scoreboard counters
    int frames_sent   = 0;
    int frames_done   = 0;
    int peaks_in_frame = 0;

    hist_peak_top hist_peak_top_inst (
        .clk        (clk),
        .combin_res (combin_res),
        .hit        (hit),
        .hit_time   (hit_time),
        .peak_valid (peak_valid),
        .peak_pixel (peak_pixel),
        .peak_bin   (peak_bin),
        .peak_count (peak_count),
        .frame_done (frame_done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on error");
    endtask

    // hit low, time code is noise that must be ignored
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            hit      = 1'b0;
            hit_time = hist_pkg::TIME_W'($urandom);
        end
    endtask

    task automatic send_hit(input int pixel, input logic [hist_pkg::TIME_W-1:0] t);
        idle_cycles($urandom_range(2, 0));
        @(negedge clk);
        hit      = 1'b1;
        hit_time = t;
        model_add(pixel, t);
    endtask

    // one frame in the fixed acq, pixel, hit order, cut at hit_limit
    task automatic send_frame(input int mode, input int hit_limit);
        logic [hist_pkg::BIN_W-1:0] pick_a [hist_pkg::PIXEL_NUM];
        logic [hist_pkg::BIN_W-1:0] pick_b [hist_pkg::PIXEL_NUM];
        logic [hist_pkg::BIN_W-1:0] bin;
        int                         sent;
        sent = 0;
        for (int p = 0; p < hist_pkg::PIXEL_NUM; p++) begin
            pick_a[p] = hist_pkg::BIN_W'($urandom);
            // always a different bin, so hit 0 and hit 1 tie
            pick_b[p] = pick_a[p] + hist_pkg::BIN_W'($urandom_range(hist_pkg::BIN_NUM - 1, 1));
        end
        for (int a = 0; a < hist_pkg::ACQ_NUM; a++) begin
            for (int p = 0; p < hist_pkg::PIXEL_NUM; p++) begin
                for (int h = 0; h < hist_pkg::HITS_PER_PIXEL; h++) begin
                    if (sent < hit_limit) begin
                        case (mode)
                            MODE_SINGLE: bin = pick_a[p];
                            MODE_TIE:    bin = (h == 0) ? pick_a[p] : pick_b[p];
                            default:     bin = hist_pkg::BIN_W'($urandom);
                        endcase
                        send_hit(p, {bin, LOW_W'($urandom)});
                        sent++;
                    end
                end
            end
        end
        if (sent == hist_pkg::FRAME_HITS) begin
            model_close_frame();
            frames_sent++;
        end
    endtask

    // consume reports, old values seen before the edge updates
    always @(posedge clk) begin
        if (peak_valid && head_valid) begin
            model_pop();
        end
        if (frame_done) begin
            peaks_in_frame <= 0;
            frames_done    <= frames_done + 1;
        end else if (peak_valid) begin
            peaks_in_frame <= peaks_in_frame + 1;
        end
    end

    // no report before a complete frame was sent
    a_peak_expected: assert property (
        @(posedge clk) disable iff (!combin_res)
        peak_valid |-> head_valid
    ) else stop_run($sformatf("Fail at %0t ns: peak report with no finished frame", $time));

    // pixel order, peak bin and count
    a_peak_value: assert property (
        @(posedge clk) disable iff (!combin_res)
        peak_valid |-> (peak_pixel == head_pixel) && (peak_bin == head_bin) &&
                       (peak_count == head_count)
    ) else stop_run($sformatf("Fail at %0t ns: got pixel %0d bin %0d count %0d, expected %0d %0d %0d",
        $time, $sampled(peak_pixel), $sampled(peak_bin), $sampled(peak_count),
        $sampled(head_pixel), $sampled(head_bin), $sampled(head_count)));

    a_peak_number: assert property (
        @(posedge clk) disable iff (!combin_res)
        peak_valid |-> (peaks_in_frame < hist_pkg::PIXEL_NUM)
    ) else stop_run($sformatf("Fail at %0t ns: more than %0d peaks in a frame",
        $time, hist_pkg::PIXEL_NUM));

    a_done_follows: assert property (
        @(posedge clk) disable iff (!combin_res)
        peak_valid && (peak_pixel == hist_pkg::PIXEL_LAST) |=> frame_done
    ) else stop_run($sformatf("Fail at %0t ns: frame_done missing after last pixel", $time));

    a_done_count: assert property (
        @(posedge clk) disable iff (!combin_res)
        frame_done |-> (peaks_in_frame == hist_pkg::PIXEL_NUM)
    ) else stop_run($sformatf("Fail at %0t ns: frame_done after %0d peaks",
        $time, $sampled(peaks_in_frame)));

    initial begin
        #(WATCHDOG_NS);
        stop_run("timeout: peak reports did not arrive within the expected run time");
    end

    initial begin
        void'($urandom(SEED));
        combin_res = 1'b0;
        hit        = 1'b0;
        hit_time   = '0;
        repeat (2) @(negedge clk);
        combin_res = 1'b1;
        // back to back frames, bank swap and clear-on-read
        send_frame(MODE_RANDOM, hist_pkg::FRAME_HITS);
        send_frame(MODE_SINGLE, hist_pkg::FRAME_HITS);
        send_frame(MODE_TIE, hist_pkg::FRAME_HITS);
        send_frame(MODE_RANDOM, hist_pkg::FRAME_HITS);
        idle_cycles(1);
        wait (frames_done == frames_sent);
        idle_cycles(3);
        // partial frame thrown away by reset
        send_frame(MODE_RANDOM, PARTIAL_HITS);
        @(negedge clk);
        combin_res = 1'b0;
        hit        = 1'b0;
        model_clear();
        repeat (2) @(negedge clk);
        combin_res = 1'b1;
        send_frame(MODE_TIE, hist_pkg::FRAME_HITS);
        send_frame(MODE_SINGLE, hist_pkg::FRAME_HITS);
        idle_cycles(1);
        wait (frames_done == frames_sent);
        idle_cycles(4);
        if (!head_valid && (peaks_in_frame == 0)) begin
            $display("** PASS **");
            $finish;
        end else begin
            stop_run("expected peak reports are still outstanding at the end of the run");
        end
    end

endmodule

`default_nettype wire
